// File: src/sparse_pkg.sv
package sparse_pkg;

	//////////////////////////////
	// Chunk geometry
	//////////////////////////////

	// Elements per chunk, one bitmap bit each
	localparam int ELEM_COUNT = 16;

	// Index of one element inside a chunk
	localparam int ADDR_W = 4;

	// Signed activation and weight width
	localparam int DATA_W = 8;

	// Packed data vector, element i at bits i*DATA_W upward
	localparam int CHUNK_W = ELEM_COUNT * DATA_W;

	// Chunk sum, 16 products of 8x8 bits fit with room to spare
	localparam int ACC_W = 24;

	//////////////////////////////
	// Buffering and flow control
	//////////////////////////////

	// Buffer slots, also the credits the sender starts with
	localparam int BUF_DEPTH = 4;

	// Scanner FSM
	typedef enum logic {
		SCAN_IDLE = 1'b0,
		SCAN_RUN  = 1'b1
	} scanner_state_e;

endpackage

// File: src/priority_encoder.sv
`timescale 1ns/1ps

module priority_encoder (
	 input  logic [sparse_pkg::ELEM_COUNT-1:0] map_i
	,output logic [sparse_pkg::ADDR_W-1:0]     index_o
	,output logic                              empty_o
);

	logic                          found;
	logic [sparse_pkg::ADDR_W-1:0] index;

	// Walk from the top down so the lowest set bit wins
	always_comb begin
		found = 1'b0;
		index = '0;
		for (int i = sparse_pkg::ELEM_COUNT - 1; i >= 0; i--) begin
			if (map_i[i]) begin
				found = 1'b1;
				index = sparse_pkg::ADDR_W'(i);
			end
		end
	end

	assign index_o = index;

	// No hit at all, index_o reads zero then
	assign empty_o = ~found;

endmodule

// File: src/match_scanner.sv
`timescale 1ns/1ps

module match_scanner (
	 input  logic                              clk_i
	,input  logic                              rst_i
	,input  logic                              head_valid_i
	,input  logic [sparse_pkg::ELEM_COUNT-1:0] ifm_map_i
	,input  logic [sparse_pkg::ELEM_COUNT-1:0] flt_map_i

	,output logic                              pop_o
	,output logic                              match_valid_o
	,output logic [sparse_pkg::ADDR_W-1:0]     match_addr_o
	,output logic                              match_last_o
);

	sparse_pkg::scanner_state_e state_q;

	logic [sparse_pkg::ELEM_COUNT-1:0] and_map;
	logic [sparse_pkg::ELEM_COUNT-1:0] remain_q;
	logic [sparse_pkg::ELEM_COUNT-1:0] scan_map;
	logic [sparse_pkg::ELEM_COUNT-1:0] next_map;
	logic [sparse_pkg::ADDR_W-1:0]     hit_addr;
	logic                              hit_empty;
	logic                              active;

	// Pairs where both operands are nonzero
	assign and_map = ifm_map_i & flt_map_i;

	// Load cycle works straight from the AND result
	assign scan_map = (state_q == sparse_pkg::SCAN_RUN) ? remain_q : and_map;

	priority_encoder u_priority_encoder (
		 .map_i   (scan_map)
		,.index_o (hit_addr)
		,.empty_o (hit_empty)
	);

	// Drop the bit reported this cycle
	always_comb begin
		next_map = scan_map;
		next_map[hit_addr] = 1'b0;
	end

	assign active = (state_q == sparse_pkg::SCAN_RUN) || head_valid_i;

	assign match_valid_o = active && !hit_empty;
	assign match_addr_o  = hit_addr;

	// Empty chunks still get a last so the MAC closes them with zero
	assign match_last_o = active && (next_map == '0);
	assign pop_o        = match_last_o;

	//////////////////////////////
	// Scan FSM
	//////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q  <= sparse_pkg::SCAN_IDLE;
			remain_q <= '0;
		end else begin
			if (active) begin
				remain_q <= next_map;
			end
			case (state_q)
				sparse_pkg::SCAN_IDLE: begin
					// More than one match left, keep walking
					if (head_valid_i && (next_map != '0)) begin
						state_q <= sparse_pkg::SCAN_RUN;
					end
				end
				sparse_pkg::SCAN_RUN: begin
					if (next_map == '0) begin
						state_q <= sparse_pkg::SCAN_IDLE;
					end
				end
				default: begin
					state_q <= sparse_pkg::SCAN_IDLE;
				end
			endcase
		end
	end

endmodule

// File: src/chunk_buffer.sv
`timescale 1ns/1ps

module chunk_buffer (
	 input  logic                              clk_i
	,input  logic                              rst_i
	,input  logic                              chunk_valid_i
	,input  logic [sparse_pkg::ELEM_COUNT-1:0] ifm_map_i
	,input  logic [sparse_pkg::ELEM_COUNT-1:0] flt_map_i
	,input  logic [sparse_pkg::CHUNK_W-1:0]    ifm_data_i
	,input  logic [sparse_pkg::CHUNK_W-1:0]    flt_data_i
	,input  logic                              pop_i

	,output logic                              head_valid_o
	,output logic [sparse_pkg::ELEM_COUNT-1:0] head_ifm_map_o
	,output logic [sparse_pkg::ELEM_COUNT-1:0] head_flt_map_o
	,output logic [sparse_pkg::CHUNK_W-1:0]    head_ifm_data_o
	,output logic [sparse_pkg::CHUNK_W-1:0]    head_flt_data_o
	,output logic                              credit_o
);

	logic [sparse_pkg::ELEM_COUNT-1:0] ifm_map_mem  [sparse_pkg::BUF_DEPTH];
	logic [sparse_pkg::ELEM_COUNT-1:0] flt_map_mem  [sparse_pkg::BUF_DEPTH];
	logic [sparse_pkg::CHUNK_W-1:0]    ifm_data_mem [sparse_pkg::BUF_DEPTH];
	logic [sparse_pkg::CHUNK_W-1:0]    flt_data_mem [sparse_pkg::BUF_DEPTH];

	logic [$clog2(sparse_pkg::BUF_DEPTH)-1:0] wr_ptr_q;
	logic [$clog2(sparse_pkg::BUF_DEPTH)-1:0] rd_ptr_q;
	logic [$clog2(sparse_pkg::BUF_DEPTH):0]   count_q;

	// Slot storage
	always_ff @(posedge clk_i) begin
		if (chunk_valid_i) begin
			ifm_map_mem[wr_ptr_q]  <= ifm_map_i;
			flt_map_mem[wr_ptr_q]  <= flt_map_i;
			ifm_data_mem[wr_ptr_q] <= ifm_data_i;
			flt_data_mem[wr_ptr_q] <= flt_data_i;
		end
	end

	//////////////////////////////
	// Pointers and occupancy
	//////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (chunk_valid_i) begin
				wr_ptr_q <= (wr_ptr_q == sparse_pkg::BUF_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
			end
			if (pop_i) begin
				rd_ptr_q <= (rd_ptr_q == sparse_pkg::BUF_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
			end
			case ({chunk_valid_i, pop_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// One credit back per freed slot
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			credit_o <= 1'b0;
		end else begin
			credit_o <= pop_i;
		end
	end

	assign head_valid_o    = (count_q != '0);
	assign head_ifm_map_o  = ifm_map_mem[rd_ptr_q];
	assign head_flt_map_o  = flt_map_mem[rd_ptr_q];
	assign head_ifm_data_o = ifm_data_mem[rd_ptr_q];
	assign head_flt_data_o = flt_data_mem[rd_ptr_q];

endmodule

// File: src/sparse_mac.sv
`timescale 1ns/1ps

module sparse_mac (
	 input  logic                                clk_i
	,input  logic                                rst_i
	,input  logic                                match_valid_i
	,input  logic [sparse_pkg::ADDR_W-1:0]       match_addr_i
	,input  logic                                match_last_i
	,input  logic [sparse_pkg::CHUNK_W-1:0]      ifm_data_i
	,input  logic [sparse_pkg::CHUNK_W-1:0]      flt_data_i

	,output logic                                sum_valid_o
	,output logic signed [sparse_pkg::ACC_W-1:0] sum_o
);

	logic signed [sparse_pkg::DATA_W-1:0]   act;
	logic signed [sparse_pkg::DATA_W-1:0]   wgt;
	logic signed [2*sparse_pkg::DATA_W-1:0] prod;
	logic signed [sparse_pkg::ACC_W-1:0]    prod_ext;
	logic signed [sparse_pkg::ACC_W-1:0]    acc_q;

	// Operand gather from the head chunk
	assign act = ifm_data_i[match_addr_i * sparse_pkg::DATA_W +: sparse_pkg::DATA_W];
	assign wgt = flt_data_i[match_addr_i * sparse_pkg::DATA_W +: sparse_pkg::DATA_W];

	assign prod = act * wgt;

	// Sign extend, zero when there is no match this cycle
	always_comb begin
		prod_ext = '0;
		if (match_valid_i) begin
			prod_ext = prod;
		end
	end

	//////////////////////////////
	// Accumulate and close
	//////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			acc_q       <= '0;
			sum_valid_o <= 1'b0;
		end else begin
			sum_valid_o <= match_last_i;
			if (match_last_i) begin
				acc_q <= '0;
			end else begin
				acc_q <= acc_q + prod_ext;
			end
		end
	end

	// Last product folds straight into the sum
	always_ff @(posedge clk_i) begin
		if (match_last_i) begin
			sum_o <= acc_q + prod_ext;
		end
	end

endmodule

// File: src/sparse_dot_top.sv
`timescale 1ns/1ps

module sparse_dot_top (
	 input  logic                                clk_i
	,input  logic                                rst_i
	,input  logic                                chunk_valid_i
	,input  logic [sparse_pkg::ELEM_COUNT-1:0]   ifm_map_i
	,input  logic [sparse_pkg::ELEM_COUNT-1:0]   flt_map_i
	,input  logic [sparse_pkg::CHUNK_W-1:0]      ifm_data_i
	,input  logic [sparse_pkg::CHUNK_W-1:0]      flt_data_i

	,output logic                                credit_o
	,output logic                                sum_valid_o
	,output logic signed [sparse_pkg::ACC_W-1:0] sum_o
);

	// Buffer head
	logic                              head_valid;
	logic [sparse_pkg::ELEM_COUNT-1:0] head_ifm_map;
	logic [sparse_pkg::ELEM_COUNT-1:0] head_flt_map;
	logic [sparse_pkg::CHUNK_W-1:0]    head_ifm_data;
	logic [sparse_pkg::CHUNK_W-1:0]    head_flt_data;

	// Scanner to buffer and MAC
	logic                              pop;
	logic                              match_valid;
	logic [sparse_pkg::ADDR_W-1:0]     match_addr;
	logic                              match_last;

	chunk_buffer u_chunk_buffer (
		 .clk_i           (clk_i)
		,.rst_i           (rst_i)
		,.chunk_valid_i   (chunk_valid_i)
		,.ifm_map_i       (ifm_map_i)
		,.flt_map_i       (flt_map_i)
		,.ifm_data_i      (ifm_data_i)
		,.flt_data_i      (flt_data_i)
		,.pop_i           (pop)
		,.head_valid_o    (head_valid)
		,.head_ifm_map_o  (head_ifm_map)
		,.head_flt_map_o  (head_flt_map)
		,.head_ifm_data_o (head_ifm_data)
		,.head_flt_data_o (head_flt_data)
		,.credit_o        (credit_o)
	);

	match_scanner u_match_scanner (
		 .clk_i         (clk_i)
		,.rst_i         (rst_i)
		,.head_valid_i  (head_valid)
		,.ifm_map_i     (head_ifm_map)
		,.flt_map_i     (head_flt_map)
		,.pop_o         (pop)
		,.match_valid_o (match_valid)
		,.match_addr_o  (match_addr)
		,.match_last_o  (match_last)
	);

	sparse_mac u_sparse_mac (
		 .clk_i         (clk_i)
		,.rst_i         (rst_i)
		,.match_valid_i (match_valid)
		,.match_addr_i  (match_addr)
		,.match_last_i  (match_last)
		,.ifm_data_i    (head_ifm_data)
		,.flt_data_i    (head_flt_data)
		,.sum_valid_o   (sum_valid_o)
		,.sum_o         (sum_o)
	);

endmodule

// File: tb/sparse_dot_props.sv
`timescale 1ns/1ps

module sparse_dot_props (
	 input logic                                      clk_i
	,input logic                                      rst_i
	,input logic [$clog2(sparse_pkg::BUF_DEPTH):0]    count_i
	,input logic                                      sum_valid_i
	,input logic                                      credit_i
	,input logic                                      match_valid_i
	,input logic [sparse_pkg::ADDR_W-1:0]             match_addr_i
	,input logic [sparse_pkg::ELEM_COUNT-1:0]         ifm_map_i
	,input logic [sparse_pkg::ELEM_COUNT-1:0]         flt_map_i
);

	// Credits keep the sender from overrunning the slots
	count_within_depth: assert property (@(posedge clk_i) disable iff (rst_i)
		count_i <= sparse_pkg::BUF_DEPTH)
		else $error("chunk buffer holds more chunks than it has slots");

	quiet_after_reset: assert property (@(posedge clk_i)
		$fell(rst_i) |-> (!sum_valid_i && !credit_i))
		else $error("sum_valid_o or credit_o high in the first cycle after reset");

	// A reported match must be nonzero on both sides
	match_in_both_maps: assert property (@(posedge clk_i) disable iff (rst_i)
		match_valid_i |-> (ifm_map_i[match_addr_i] && flt_map_i[match_addr_i]))
		else $error("match reported at an index missing from a head bitmap");

endmodule

bind sparse_dot_top sparse_dot_props u_props (
	 .clk_i         (clk_i)
	,.rst_i         (rst_i)
	,.count_i       (u_chunk_buffer.count_q)
	,.sum_valid_i   (sum_valid_o)
	,.credit_i      (credit_o)
	,.match_valid_i (match_valid)
	,.match_addr_i  (match_addr)
	,.ifm_map_i     (head_ifm_map)
	,.flt_map_i     (head_flt_map)
);

// File: tb/sparse_dot_checker.sv
`timescale 1ns/1ps

module sparse_dot_checker (
	 input logic                                clk_i
	,input logic                                rst_i
	,input logic                                credit_i
	,input logic                                sum_valid_i
	,input logic signed [sparse_pkg::ACC_W-1:0] sum_i
);

	int expected_q[$];
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	int credit_count = 0;
	int sums_seen = 0;
	int errors_before = 0;
	int checks_before = 0;

	task automatic push_expected(input int value);
		expected_q.push_back(value);
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		check_count++;
		if (got != exp) begin
			error_count++;
			$display("CHECK FAILED at %0d ns: %s expected %0d, got %0d",
				$time, name, exp, got);
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("Test %-8s done: %0d checks, %0d errors", name,
			check_count - checks_before, error_count - errors_before);
		checks_before = check_count;
		errors_before = error_count;
	endtask

	task automatic report_totals();
		$display("Totals: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
	endtask

	//////////////////////////////
	// Output monitor
	//////////////////////////////

	// Outputs are registered, so they are settled at the falling edge
	always @(negedge clk_i) begin
		if (rst_i) begin
			check_count++;
			if (sum_valid_i !== 1'b0 || credit_i !== 1'b0) begin
				error_count++;
				$display("Output active during reset at %0d ns", $time);
			end
		end else begin
			if (credit_i) begin
				credit_count++;
			end
			if (sum_valid_i) begin
				sums_seen++;
				if (expected_q.size() == 0) begin
					error_count++;
					$display("Sum %0d at %0d ns with no chunk outstanding", sum_i, $time);
				end else begin
					check_value("sum_o", int'(sum_i), expected_q.pop_front());
				end
			end
		end
	end

endmodule

// File: tb/tb_sparse_dot.sv
`timescale 1ns/1ps

module tb_sparse_dot;

	localparam int RESET_CYCLES = 8;
	localparam int N_RANDOM = 40;
	localparam int N_DISJOINT = 10;
	localparam int N_DENSE = 8;
	localparam int TOTAL_CHUNKS = N_RANDOM + N_DISJOINT + N_DENSE + 2 * sparse_pkg::BUF_DEPTH;

	logic                                clk_i = 1'b0;
	logic                                rst_i = 1'b1;
	logic                                chunk_valid_i = 1'b0;
	logic [sparse_pkg::ELEM_COUNT-1:0]   ifm_map_i = '0;
	logic [sparse_pkg::ELEM_COUNT-1:0]   flt_map_i = '0;
	logic [sparse_pkg::CHUNK_W-1:0]      ifm_data_i = '0;
	logic [sparse_pkg::CHUNK_W-1:0]      flt_data_i = '0;
	logic                                credit_o;
	logic                                sum_valid_o;
	logic signed [sparse_pkg::ACC_W-1:0] sum_o;

	logic [31:0] lfsr = 32'h7154_7827;
	int          credits = sparse_pkg::BUF_DEPTH;
	int          sent = 0;

	always #20 clk_i = ~clk_i;

	sparse_dot_top UUT (
		 .clk_i (clk_i), .rst_i (rst_i), .chunk_valid_i (chunk_valid_i)
		,.ifm_map_i (ifm_map_i), .flt_map_i (flt_map_i)
		,.ifm_data_i (ifm_data_i), .flt_data_i (flt_data_i)
		,.credit_o (credit_o), .sum_valid_o (sum_valid_o), .sum_o (sum_o)
	);

	sparse_dot_checker u_checker (
		 .clk_i (clk_i), .rst_i (rst_i), .credit_i (credit_o)
		,.sum_valid_i (sum_valid_o), .sum_i (sum_o)
	);

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
	function automatic logic [sparse_pkg::CHUNK_W-1:0] take_bits(input int n);
		logic [sparse_pkg::CHUNK_W-1:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			bits = {bits[sparse_pkg::CHUNK_W-2:0], lfsr[0]};
		end
		return bits;
	endfunction

	// Dot product over the indices set in both bitmaps
	function automatic int model_sum(input logic [15:0] im, input logic [15:0] fm,
			input logic [sparse_pkg::CHUNK_W-1:0] id, input logic [sparse_pkg::CHUNK_W-1:0] fd);
		int                   acc;
		logic signed [7:0]    a;
		logic signed [7:0]    w;
		acc = 0;
		for (int i = 0; i < sparse_pkg::ELEM_COUNT; i++) begin
			if (im[i] && fm[i]) begin
				a = id[i*sparse_pkg::DATA_W +: sparse_pkg::DATA_W];
				w = fd[i*sparse_pkg::DATA_W +: sparse_pkg::DATA_W];
				acc += int'(a) * int'(w);
			end
		end
		return acc;
	endfunction

	// Every falling edge passes through here so no credit pulse is missed
	task automatic next_cycle();
		@(negedge clk_i);
		if (credit_o) begin
			credits++;
		end
	endtask

	task automatic send_chunk(input logic [15:0] im, input logic [15:0] fm,
			input logic [sparse_pkg::CHUNK_W-1:0] id, input logic [sparse_pkg::CHUNK_W-1:0] fd);
		while (credits == 0) begin
			next_cycle();
		end
		chunk_valid_i = 1'b1;
		ifm_map_i = im;
		flt_map_i = fm;
		ifm_data_i = id;
		flt_data_i = fd;
		u_checker.push_expected(model_sum(im, fm, id, fd));
		credits--;
		sent++;
		next_cycle();
		chunk_valid_i = 1'b0;
	endtask

	// Wait for every sum, then compare the credits that came back
	task automatic drain(input string name);
		while (u_checker.sums_seen < sent) begin
			next_cycle();
		end
		next_cycle();
		u_checker.check_value("sender credits", credits, sparse_pkg::BUF_DEPTH);
		u_checker.end_test(name);
	endtask

	initial begin
		logic [sparse_pkg::CHUNK_W-1:0] map;
		logic [sparse_pkg::CHUNK_W-1:0] act;
		logic [sparse_pkg::CHUNK_W-1:0] wgt;
		repeat (RESET_CYCLES) next_cycle();
		rst_i = 1'b0;
		repeat (4) next_cycle();
		u_checker.end_test("reset");
		for (int n = 0; n < N_RANDOM; n++) begin
			map = take_bits(32);
			send_chunk(map[15:0], map[31:16], take_bits(128), take_bits(128));
		end
		drain("random");
		for (int n = 0; n < N_DISJOINT; n++) begin
			map = take_bits(16);
			send_chunk(map[15:0], ~map[15:0], take_bits(128), take_bits(128));
		end
		drain("disjoint");
		// Full maps with extreme values first and random values after
		for (int n = 0; n < N_DENSE; n++) begin
			act = (n == 0) ? {16{8'h80}} : (n < 3) ? {16{8'h7f}} : take_bits(128);
			wgt = (n < 2) ? {16{8'h80}} : (n == 2) ? {16{8'h7f}} : take_bits(128);
			send_chunk('1, '1, act, wgt);
		end
		drain("dense");
		repeat (sparse_pkg::BUF_DEPTH) send_chunk('1, '1, take_bits(128), take_bits(128));
		u_checker.check_value("sender credits after burst", credits, 0);
		repeat (sparse_pkg::BUF_DEPTH) send_chunk('1, '1, take_bits(128), take_bits(128));
		drain("credit");
		u_checker.check_value("credit_o pulses", u_checker.credit_count, sent);
		u_checker.report_totals();
		if (u_checker.error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Watchdog sized at 20 cycles per chunk plus reset
	initial begin
		repeat (TOTAL_CHUNKS * 20 + RESET_CYCLES) @(posedge clk_i);
		$display("Timeout: sums or credits still missing after %0d cycles",
			TOTAL_CHUNKS * 20 + RESET_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: sparse_dot_top.f
src/sparse_pkg.sv
src/priority_encoder.sv
src/match_scanner.sv
src/chunk_buffer.sv
src/sparse_mac.sv
src/sparse_dot_top.sv
tb/sparse_dot_props.sv
tb/sparse_dot_checker.sv
tb/tb_sparse_dot.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sparse_dot
FILELIST  ?= sparse_dot_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
